// File: mem_pkg.sv
`default_nettype none

// memory side word types shared by the queue, the select logic and the drain
package mem_pkg;

	// widths of the data memory port
	localparam int addr_width = 32; // word address
	localparam int data_width = 64; // one store is one full double word

	// word address of a store or a load
	typedef logic [addr_width-1:0] address_t;

	// full width store payload
	typedef logic [data_width-1:0] store_data_t;

	// no byte enables on this port
	// partial stores never reach here

endpackage

`default_nettype wire

// File: sq_pkg.sv
`default_nettype none

// store queue sizing and drain FSM encoding
package sq_pkg;

	// default number of queue entries, keep it a power of two
	localparam int sq_depth_default = 8;

	// default number of memory writes that may be outstanding
	localparam int mem_credits_default = 2;

	// drain FSM states
	typedef enum logic [1:0] {
		drain_idle,  // waiting for a committed head
		drain_write, // holding the head until a memory credit is free
		drain_free   // write issued, release the head entry
	} drain_state_t;

	// one store leaves the queue every three cycles at best

endpackage

`default_nettype wire

// File: forward_select.sv
`timescale 1ns/10ps
`default_nettype none

module forward_select #(
	parameter int SQ_DEPTH = sq_pkg::sq_depth_default,
	localparam int IDX_W = $clog2(SQ_DEPTH)
) (
	// offset 0 is the oldest store
	input logic [SQ_DEPTH-1:0] entry_valid,
	input logic [SQ_DEPTH-1:0] entry_addr_ready,
	input logic [SQ_DEPTH-1:0] entry_data_ready,
	input mem_pkg::address_t [SQ_DEPTH-1:0] entry_addr,

	input logic ld_en,
	input mem_pkg::address_t ld_addr,
	input logic [IDX_W-1:0] ld_age, // offsets below this are older than the load

	output logic fwd_hit,
	output logic fwd_stall,
	output logic [IDX_W-1:0] win_offset
);

	logic [SQ_DEPTH-1:0] older;
	logic [SQ_DEPTH-1:0] addr_match;
	logic addr_unknown;
	logic match_found;

	for (genvar k = 0; k < SQ_DEPTH; k++) begin : g_cmp
		assign older[k] = entry_valid[k] && (IDX_W'(k) < ld_age);
		assign addr_match[k] = older[k] && entry_addr_ready[k]
			&& (entry_addr[k] == ld_addr);
	end

	// an older store with no address yet might alias the load
	assign addr_unknown = |(older & ~entry_addr_ready);

	// youngest match wins, so scan down from the top offset
	always_comb begin
		match_found = 1'b0;
		win_offset = '0;
		for (int k = SQ_DEPTH - 1; k >= 0; k--) begin
			if (addr_match[k] && !match_found) begin
				match_found = 1'b1;
				win_offset = IDX_W'(k);
			end
		end
	end

	assign fwd_stall = ld_en
		&& (addr_unknown || (match_found && !entry_data_ready[win_offset]));
	assign fwd_hit = ld_en && match_found && !fwd_stall; // neither means miss

endmodule

`default_nettype wire

// File: store_queue.sv
`timescale 1ns/10ps
`default_nettype none

module store_queue #(
	parameter int SQ_DEPTH = sq_pkg::sq_depth_default,
	localparam int IDX_W = $clog2(SQ_DEPTH)
) (
	input logic clock,
	input logic reset,

	// dispatch, in program order
	input logic dispatch_en,
	input mem_pkg::address_t dispatch_addr,
	input logic dispatch_addr_ready,
	input mem_pkg::store_data_t dispatch_data,
	input logic dispatch_data_ready,

	// execute, by slot index
	input logic ex_en,
	input logic [IDX_W-1:0] ex_index,
	input mem_pkg::address_t ex_addr,
	input logic ex_addr_en,
	input mem_pkg::store_data_t ex_data,
	input logic ex_data_en,

	input logic rt_en, // commit the oldest uncommitted store

	// load search
	input logic ld_en,
	input mem_pkg::address_t ld_addr,
	input logic [IDX_W-1:0] ld_pos, // tail seen by the load at dispatch

	input logic head_free, // from the drain, head entry written

	output logic [IDX_W-1:0] sq_tail,
	output logic dispatch_credit,
	output logic fwd_hit,
	output logic fwd_stall,
	output mem_pkg::store_data_t fwd_data,
	output logic head_committed,
	output mem_pkg::address_t head_addr,
	output mem_pkg::store_data_t head_data
);

	import mem_pkg::*;

	localparam int PTR_W = IDX_W + 1; // index plus wrap bit

	// entry storage
	address_t st_addr [SQ_DEPTH];
	store_data_t st_data [SQ_DEPTH];
	logic [SQ_DEPTH-1:0] st_addr_ready;
	logic [SQ_DEPTH-1:0] st_data_ready;

	// head <= commit <= tail in age order
	logic [PTR_W-1:0] head;
	logic [PTR_W-1:0] commit;
	logic [PTR_W-1:0] tail;
	logic [IDX_W-1:0] head_idx;
	logic [IDX_W-1:0] tail_idx;
	logic [PTR_W-1:0] occupancy;

	// entries rotated so offset 0 is the oldest
	logic [SQ_DEPTH-1:0] age_valid;
	logic [SQ_DEPTH-1:0] age_addr_ready;
	logic [SQ_DEPTH-1:0] age_data_ready;
	address_t [SQ_DEPTH-1:0] age_addr;

	logic [IDX_W-1:0] ld_age; // number of slots older than the load
	logic [IDX_W-1:0] win_offset;
	logic [IDX_W-1:0] win_idx;

	assign head_idx = head[IDX_W-1:0];
	assign tail_idx = tail[IDX_W-1:0];
	assign occupancy = tail - head; // wrap bit makes full distinct from empty

	assign sq_tail = tail_idx; // slot of a dispatch in this cycle
	assign dispatch_credit = head_free; // every freed slot returns one credit

	// drain interface
	assign head_committed = (head != commit);
	assign head_addr = st_addr[head_idx];
	assign head_data = st_data[head_idx];

	always_ff @(posedge clock) begin
		if (reset) begin
			head <= '0;
			commit <= '0;
			tail <= '0;
		end else begin
			if (head_free)
				head <= head + PTR_W'(1);
			if (rt_en)
				commit <= commit + PTR_W'(1); // retire is always in order
			if (dispatch_en)
				tail <= tail + PTR_W'(1);
		end
	end

	// execute first, then dispatch, so a dispatch write is the last one
	always_ff @(posedge clock) begin
		if (ex_en) begin
			if (ex_addr_en) begin
				st_addr[ex_index] <= ex_addr;
				st_addr_ready[ex_index] <= 1'b1;
			end
			if (ex_data_en) begin
				st_data[ex_index] <= ex_data;
				st_data_ready[ex_index] <= 1'b1;
			end
		end
		if (dispatch_en) begin
			st_addr[tail_idx] <= dispatch_addr;
			st_addr_ready[tail_idx] <= dispatch_addr_ready; // direct store has it now
			st_data[tail_idx] <= dispatch_data;
			st_data_ready[tail_idx] <= dispatch_data_ready;
		end
	end

	// rotate registered state into age order for the search
	for (genvar k = 0; k < SQ_DEPTH; k++) begin : g_age
		logic [IDX_W-1:0] slot;

		assign slot = head_idx + IDX_W'(k);
		assign age_valid[k] = PTR_W'(k) < occupancy;
		assign age_addr_ready[k] = st_addr_ready[slot];
		assign age_data_ready[k] = st_data_ready[slot];
		assign age_addr[k] = st_addr[slot];
	end

	// slots from head up to ld_pos are older than the load
	assign ld_age = ld_pos - head_idx;

	forward_select #(
		.SQ_DEPTH(SQ_DEPTH)
	) i_forward_select (
		.entry_valid(age_valid),
		.entry_addr_ready(age_addr_ready),
		.entry_data_ready(age_data_ready),
		.entry_addr(age_addr),
		.ld_en(ld_en),
		.ld_addr(ld_addr),
		.ld_age(ld_age),
		.fwd_hit(fwd_hit),
		.fwd_stall(fwd_stall),
		.win_offset(win_offset)
	);

	// back from age offset to a physical slot
	assign win_idx = head_idx + win_offset;
	assign fwd_data = st_data[win_idx]; // only meaningful with fwd_hit

endmodule

`default_nettype wire

// File: store_drain.sv
`timescale 1ns/10ps
`default_nettype none

module store_drain #(
	parameter int SQ_DEPTH = sq_pkg::sq_depth_default,
	parameter int MEM_CREDITS = sq_pkg::mem_credits_default,
	localparam int CNT_W = $clog2(MEM_CREDITS) + 1
) (
	input logic clock,
	input logic reset,

	input logic head_committed,
	input mem_pkg::address_t head_addr,
	input mem_pkg::store_data_t head_data,
	input logic mem_credit, // one write accepted by memory

	output logic mem_wr_en,
	output mem_pkg::address_t mem_wr_addr,
	output mem_pkg::store_data_t mem_wr_data,
	output logic head_free
);

	import sq_pkg::*;

	drain_state_t state;
	drain_state_t state_next;
	logic [CNT_W-1:0] credit_cnt; // writes memory can still take
	logic has_credit;

	// queue slots are indexed by wrapping pointers
	if (SQ_DEPTH < 2 || (SQ_DEPTH & (SQ_DEPTH - 1)) != 0)
		$error("store_drain: SQ_DEPTH must be a power of two, at least 2");

	assign has_credit = (credit_cnt != '0);

	assign mem_wr_en = (state == drain_write) && has_credit;
	assign head_free = (state == drain_free);
	// head entry is stable until head_free
	assign mem_wr_addr = head_addr;
	assign mem_wr_data = head_data;

	always_comb begin
		state_next = state;
		case (state)
			drain_idle:  if (head_committed) state_next = drain_write;
			drain_write: if (has_credit) state_next = drain_free; // else wait on memory
			drain_free:  state_next = drain_idle;
			default:     state_next = drain_idle;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset)
			state <= drain_idle;
		else
			state <= state_next;
	end

	// a write and a returned credit in one cycle cancel out
	always_ff @(posedge clock) begin
		if (reset) begin
			credit_cnt <= CNT_W'(MEM_CREDITS);
		end else begin
			case ({mem_wr_en, mem_credit})
				2'b10:   credit_cnt <= credit_cnt - CNT_W'(1);
				2'b01:   credit_cnt <= credit_cnt + CNT_W'(1);
				default: credit_cnt <= credit_cnt;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: store_subsystem.sv
`timescale 1ns/10ps
`default_nettype none

module store_subsystem #(
	parameter int SQ_DEPTH = sq_pkg::sq_depth_default,
	parameter int MEM_CREDITS = sq_pkg::mem_credits_default,
	localparam int IDX_W = $clog2(SQ_DEPTH)
) (
	input logic clock,
	input logic reset,

	input logic dispatch_en,
	input mem_pkg::address_t dispatch_addr,
	input logic dispatch_addr_ready,
	input mem_pkg::store_data_t dispatch_data,
	input logic dispatch_data_ready,
	output logic [IDX_W-1:0] sq_tail,
	output logic dispatch_credit,

	input logic ex_en,
	input logic [IDX_W-1:0] ex_index,
	input mem_pkg::address_t ex_addr,
	input logic ex_addr_en,
	input mem_pkg::store_data_t ex_data,
	input logic ex_data_en,

	input logic rt_en,

	input logic ld_en,
	input mem_pkg::address_t ld_addr,
	input logic [IDX_W-1:0] ld_pos,
	output logic fwd_hit,
	output logic fwd_stall,
	output mem_pkg::store_data_t fwd_data,

	output logic mem_wr_en,
	output mem_pkg::address_t mem_wr_addr,
	output mem_pkg::store_data_t mem_wr_data,
	input logic mem_credit
);

	import mem_pkg::*;

	// queue head toward the drain
	logic head_committed;
	address_t head_addr;
	store_data_t head_data;
	logic head_free;

	store_queue #(
		.SQ_DEPTH(SQ_DEPTH)
	) i_store_queue (
		.clock(clock),
		.reset(reset),
		.dispatch_en(dispatch_en),
		.dispatch_addr(dispatch_addr),
		.dispatch_addr_ready(dispatch_addr_ready),
		.dispatch_data(dispatch_data),
		.dispatch_data_ready(dispatch_data_ready),
		.ex_en(ex_en),
		.ex_index(ex_index),
		.ex_addr(ex_addr),
		.ex_addr_en(ex_addr_en),
		.ex_data(ex_data),
		.ex_data_en(ex_data_en),
		.rt_en(rt_en),
		.ld_en(ld_en),
		.ld_addr(ld_addr),
		.ld_pos(ld_pos),
		.head_free(head_free),
		.sq_tail(sq_tail),
		.dispatch_credit(dispatch_credit),
		.fwd_hit(fwd_hit),
		.fwd_stall(fwd_stall),
		.fwd_data(fwd_data),
		.head_committed(head_committed),
		.head_addr(head_addr),
		.head_data(head_data)
	);

	store_drain #(
		.SQ_DEPTH(SQ_DEPTH),
		.MEM_CREDITS(MEM_CREDITS)
	) i_store_drain (
		.clock(clock),
		.reset(reset),
		.head_committed(head_committed),
		.head_addr(head_addr),
		.head_data(head_data),
		.mem_credit(mem_credit),
		.mem_wr_en(mem_wr_en),
		.mem_wr_addr(mem_wr_addr),
		.mem_wr_data(mem_wr_data),
		.head_free(head_free)
	);

endmodule

`default_nettype wire

// File: store_subsystem_assert.sv
`timescale 1ns/10ps
`default_nettype none

module store_subsystem_assert #(
	parameter int SQ_DEPTH = sq_pkg::sq_depth_default,
	parameter int MEM_CREDITS = sq_pkg::mem_credits_default
) (
	input logic clock,
	input logic reset,
	input logic dispatch_en,
	input logic dispatch_credit,
	input logic mem_wr_en,
	input logic mem_credit,
	input logic fwd_hit,
	input logic fwd_stall
);

	int mem_left; // memory credits not yet spent
	int in_flight; // dispatched slots not yet handed back
	int fail_cnt = 0; // read by the testbench

	always_ff @(posedge clock) begin
		if (reset) begin
			mem_left <= MEM_CREDITS;
			in_flight <= 0;
		end else begin
			mem_left <= mem_left - int'(mem_wr_en) + int'(mem_credit);
			in_flight <= in_flight + int'(dispatch_en) - int'(dispatch_credit);
		end
	end

	a_write_credit: assert property (@(posedge clock) disable iff (reset)
		mem_wr_en |-> mem_left > 0)
		else begin
			fail_cnt = fail_cnt + 1;
			$error("memory write issued with no memory credit left");
		end

	a_fwd_onehot: assert property (@(posedge clock) disable iff (reset)
		!(fwd_hit && fwd_stall))
		else begin
			fail_cnt = fail_cnt + 1;
			$error("fwd_hit and fwd_stall high together");
		end

	a_dispatch_bound: assert property (@(posedge clock) disable iff (reset)
		in_flight <= SQ_DEPTH)
		else begin
			fail_cnt = fail_cnt + 1;
			$error("more than SQ_DEPTH dispatches outstanding");
		end

	// a write releases its slot in the following cycle
	a_write_then_free: assert property (@(posedge clock) disable iff (reset)
		mem_wr_en |=> dispatch_credit)
		else begin
			fail_cnt = fail_cnt + 1;
			$error("no dispatch_credit in the cycle after a memory write");
		end

endmodule

bind store_subsystem store_subsystem_assert #(
	.SQ_DEPTH(SQ_DEPTH),
	.MEM_CREDITS(MEM_CREDITS)
) i_assert (
	.clock(clock),
	.reset(reset),
	.dispatch_en(dispatch_en),
	.dispatch_credit(dispatch_credit),
	.mem_wr_en(mem_wr_en),
	.mem_credit(mem_credit),
	.fwd_hit(fwd_hit),
	.fwd_stall(fwd_stall)
);

`default_nettype wire

// File: tb_store_subsystem.sv
`timescale 1ns/10ps
`default_nettype none

module tb_store_subsystem;

	import mem_pkg::*;
	import sq_pkg::*;

	localparam int depth = sq_depth_default;
	localparam int mem_credits = mem_credits_default;
	localparam int idx_w = $clog2(depth);
	localparam int half_period = 10;
	localparam int num_tests = 5;
	localparam address_t addr_x = 32'h0000_2000; // address shared by several stores
	localparam address_t addr_y = 32'h0000_2001;
	localparam address_t addr_z = 32'h0000_2002; // never stored to
	localparam address_t addr_v = 32'h0000_2003;
	localparam address_t addr_w = 32'h0000_2004;

	logic clock = 1'b0;
	logic reset;
	logic dispatch_en, dispatch_addr_ready, dispatch_data_ready, dispatch_credit;
	logic ex_en, ex_addr_en, ex_data_en, rt_en, ld_en;
	logic fwd_hit, fwd_stall, mem_wr_en, mem_credit;
	logic [idx_w-1:0] sq_tail, ex_index, ld_pos;
	address_t dispatch_addr, ex_addr, ld_addr, mem_wr_addr;
	store_data_t dispatch_data, ex_data, fwd_data, mem_wr_data;

	// model state per slot with stores counted in program order
	address_t m_addr [depth];
	store_data_t m_data [depth];
	logic m_aready [depth];
	logic m_dready [depth];
	int disp_cnt = 0, rt_cnt = 0, wr_cnt = 0, free_cnt = 0;
	int mem_avail = mem_credits; // memory credits held by the drain
	int cycle = 0;
	int due [$]; // cycles at which memory hands a credit back
	logic mem_hold = 1'b0; // memory keeps its credits while set
	logic credit_go = 1'b0;

	store_subsystem #(
		.SQ_DEPTH(depth),
		.MEM_CREDITS(mem_credits)
	) i_dut (.*);

	always #half_period clock = ~clock;
	always @(posedge clock) cycle <= cycle + 1;

	always @(posedge clock) begin
		#2;
		mem_credit = credit_go;
	end

	task automatic stop_failed();
		$display("FAIL: see errors above");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic fail_run(input string msg);
		$display("error %0t: %s", $time, msg);
		stop_failed();
	endtask

	function automatic store_data_t rand_data();
		return {$urandom, $urandom};
	endfunction

	// youngest older store at the address wins and an unknown older address stalls
	function automatic void expect_load(input address_t a, input int lseq,
		output logic hit, output logic stall, output store_data_t data);
		int slot;
		logic found;
		hit = 1'b0;
		stall = 1'b0;
		data = '0;
		found = 1'b0;
		for (int s = lseq - 1; s >= free_cnt; s--) begin
			slot = s % depth;
			if (!m_aready[slot]) begin
				stall = 1'b1;
			end else if (!found && m_addr[slot] == a) begin
				found = 1'b1;
				data = m_data[slot];
				stall = stall || !m_dready[slot];
			end
		end
		hit = found && !stall;
	endfunction

	task automatic step();
		@(posedge clock);
		#2;
		dispatch_en = 1'b0;
		ex_en = 1'b0;
		rt_en = 1'b0;
		ld_en = 1'b0;
	endtask

	task automatic dispatch_store(input address_t addr, input logic addr_ok,
		input store_data_t data, input logic data_ok);
		int slot;
		while (disp_cnt - free_cnt >= depth)
			step(); // out of dispatch credits
		slot = disp_cnt % depth;
		assert (sq_tail == idx_w'(slot)) else fail_run("sq_tail is not the next slot");
		dispatch_en = 1'b1;
		dispatch_addr = addr;
		dispatch_addr_ready = addr_ok;
		dispatch_data = data;
		dispatch_data_ready = data_ok;
		m_addr[slot] = addr;
		m_aready[slot] = addr_ok;
		m_data[slot] = data;
		m_dready[slot] = data_ok;
		disp_cnt++;
		step();
	endtask

	task automatic execute_store(input int seq, input address_t addr, input logic addr_en,
		input store_data_t data, input logic data_en);
		int slot;
		slot = seq % depth;
		ex_en = 1'b1;
		ex_index = idx_w'(slot);
		ex_addr = addr;
		ex_addr_en = addr_en;
		ex_data = data;
		ex_data_en = data_en;
		if (addr_en) begin
			m_addr[slot] = addr;
			m_aready[slot] = 1'b1;
		end
		if (data_en) begin
			m_data[slot] = data;
			m_dready[slot] = 1'b1;
		end
		step();
	endtask

	task automatic retire_store();
		rt_en = 1'b1;
		rt_cnt++;
		step();
	endtask

	task automatic drain_all();
		while (rt_cnt < disp_cnt)
			retire_store();
		while (free_cnt < disp_cnt)
			step();
	endtask

	// lseq is the program order position the load saw at dispatch
	task automatic load_check(input address_t addr, input int lseq);
		logic exp_hit;
		logic exp_stall;
		store_data_t exp_data;
		expect_load(addr, lseq, exp_hit, exp_stall, exp_data);
		ld_en = 1'b1;
		ld_addr = addr;
		ld_pos = idx_w'(lseq % depth);
		#5;
		assert (fwd_hit == exp_hit && fwd_stall == exp_stall)
			else fail_run($sformatf("load seq %0d got hit %b stall %b, expected %b %b",
				lseq, fwd_hit, fwd_stall, exp_hit, exp_stall));
		assert (!exp_hit || fwd_data == exp_data)
			else fail_run($sformatf("load seq %0d forwarded %h, expected %h",
				lseq, fwd_data, exp_data));
		step();
	endtask

	// checked mid cycle when everything driven at +2 has settled
	always @(negedge clock) begin : watch_outputs
		int slot;
		int pick;
		if (!reset) begin
			if (mem_wr_en) begin
				slot = wr_cnt % depth;
				assert (rt_cnt > wr_cnt) else fail_run("memory write before its retire");
				assert (mem_avail > 0) else fail_run("memory write with no memory credit");
				assert (mem_wr_addr == m_addr[slot] && mem_wr_data == m_data[slot])
					else fail_run($sformatf("write %0d carries %h %h, expected %h %h", wr_cnt,
						mem_wr_addr, mem_wr_data, m_addr[slot], m_data[slot]));
				wr_cnt++;
				mem_avail--;
				due.push_back(cycle + 1 + int'($urandom % 4)); // 1 to 4 cycles
			end
			if (mem_credit)
				mem_avail++;
			if (dispatch_credit) begin
				assert (free_cnt < wr_cnt) else fail_run("dispatch_credit with no write before it");
				free_cnt++;
			end
			pick = -1;
			if (!mem_hold)
				foreach (due[k])
					if (pick < 0 && due[k] <= cycle + 1)
						pick = k;
			credit_go = (pick >= 0); // pulse in the next cycle
			if (pick >= 0)
				due.delete(pick);
			if (i_dut.i_assert.fail_cnt != 0) begin
				$display("a bound concurrent assertion failed, see the messages above");
				stop_failed();
			end
		end
	end

	initial begin : watchdog
		#(num_tests * 400 * 2 * half_period);
		$display("watchdog expired, the tests did not finish in time");
		stop_failed();
	end

	initial begin : main
		int base;
		int w0;
		store_data_t d1;
		store_data_t d2;
		store_data_t d3;
		void'($urandom(32'h2656));
		reset = 1'b1;
		mem_credit = 1'b0;
		{dispatch_en, dispatch_addr_ready, dispatch_data_ready} = '0;
		{ex_en, ex_addr_en, ex_data_en, rt_en, ld_en} = '0;
		dispatch_addr = '0;
		dispatch_data = '0;
		ex_index = '0;
		ex_addr = '0;
		ex_data = '0;
		ld_addr = '0;
		ld_pos = '0;
		repeat (4) @(posedge clock);
		#2;
		reset = 1'b0;

		// reset state and dispatch credits
		assert (!mem_wr_en && !dispatch_credit && !fwd_hit && !fwd_stall && sq_tail == '0)
			else fail_run("outputs not low after reset");
		for (int i = 0; i < depth; i++)
			dispatch_store(32'h100 + i, 1'b1, rand_data(), 1'b1);
		load_check(32'h100 + depth - 2, depth - 1); // every slot still holds its store
		retire_store();
		dispatch_store(32'h200, 1'b1, rand_data(), 1'b1); // needs the one returned credit
		drain_all();

		// forwarding and age bound on the address
		base = disp_cnt;
		d1 = rand_data();
		d2 = rand_data();
		d3 = rand_data();
		dispatch_store(addr_x, 1'b1, d1, 1'b1);
		dispatch_store(addr_y, 1'b1, rand_data(), 1'b1);
		dispatch_store(addr_x, 1'b1, d2, 1'b1);
		load_check(addr_x, base + 3); // youngest x
		load_check(addr_x, base + 2); // third store is younger than the load
		load_check(addr_z, base + 3); // miss
		load_check(addr_x, base); // nothing older

		// stall on unknown address and then on data not ready
		dispatch_store('0, 1'b0, rand_data(), 1'b1);
		load_check(addr_x, base + 4);
		execute_store(base + 3, addr_w, 1'b1, '0, 1'b0);
		load_check(addr_x, base + 4);
		dispatch_store(addr_x, 1'b1, '0, 1'b0);
		load_check(addr_x, base + 5);
		execute_store(base + 4, '0, 1'b0, d3, 1'b1);
		load_check(addr_x, base + 5);

		// store dispatched at the load position
		dispatch_store(addr_v, 1'b1, rand_data(), 1'b1);
		load_check(addr_v, base + 5);
		load_check(addr_v, base + 6);

		// drain with memory credits held back
		while (due.size() != 0 || mem_avail != mem_credits)
			step();
		mem_hold = 1'b1;
		w0 = wr_cnt;
		while (rt_cnt < disp_cnt)
			retire_store();
		repeat (30) step();
		assert (wr_cnt - w0 == mem_credits)
			else fail_run($sformatf("%0d writes with credits held, expected %0d",
				wr_cnt - w0, mem_credits));
		mem_hold = 1'b0;
		drain_all();

		if (i_dut.i_assert.fail_cnt != 0) begin
			$display("a bound concurrent assertion failed, see the messages above");
			stop_failed();
		end else begin
			$display("PASS: all tests");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: store_subsystem.f
mem_pkg.sv
sq_pkg.sv
forward_select.sv
store_queue.sv
store_drain.sv
store_subsystem.sv
store_subsystem_assert.sv
tb_store_subsystem.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the store subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_store_subsystem \
	-f store_subsystem.f -o sim_tb

# keep running past an assertion so the testbench can report it
./obj_dir/sim_tb +verilator+error+limit+100 | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"
